/* rtl/dlx_isa_pkg.sv */
`default_nettype none

package dlx_isa_pkg;

   typedef logic [0:31] instr_t;   // Bit 0 is the MSB, big-endian numbering
   typedef logic [5:0]  opcode_t;
   typedef logic [4:0]  reg_sel_t;
   typedef logic [31:0] word_t;

   localparam opcode_t op_rtype = 6'h00;
   localparam opcode_t op_j     = 6'h02;
   localparam opcode_t op_jal   = 6'h03;
   localparam opcode_t op_beqz  = 6'h04;
   localparam opcode_t op_bnez  = 6'h05;
   localparam opcode_t op_addi  = 6'h08;
   localparam opcode_t op_addui = 6'h09;
   localparam opcode_t op_subi  = 6'h0a;
   localparam opcode_t op_subui = 6'h0b;
   localparam opcode_t op_jr    = 6'h12;
   localparam opcode_t op_jalr  = 6'h13;
   localparam opcode_t op_sgei  = 6'h1d;
   localparam opcode_t op_lb    = 6'h20;
   localparam opcode_t op_lh    = 6'h21;
   localparam opcode_t op_lw    = 6'h23;
   localparam opcode_t op_sb    = 6'h28;
   localparam opcode_t op_sh    = 6'h29;
   localparam opcode_t op_sw    = 6'h2b;

   // Function codes, valid under op_rtype only
   localparam opcode_t fn_nop  = 6'h15;
   localparam opcode_t fn_add  = 6'h20;
   localparam opcode_t fn_addu = 6'h21;
   localparam opcode_t fn_sub  = 6'h22;
   localparam opcode_t fn_subu = 6'h23;
   localparam opcode_t fn_xor  = 6'h26;
   localparam opcode_t fn_slt  = 6'h2a;

   function automatic opcode_t opcode_of(instr_t i);
      return i[0:5];
   endfunction

   function automatic opcode_t func_of(instr_t i);
      return i[26:31];
   endfunction

   function automatic reg_sel_t rd_i_of(instr_t i);
      return i[11:15];   // Also the rs2 field
   endfunction

   function automatic reg_sel_t rd_r_of(instr_t i);
      return i[16:20];
   endfunction

   function automatic logic [15:0] imm16_of(instr_t i);
      return i[16:31];
   endfunction

   function automatic logic [25:0] off26_of(instr_t i);
      return i[6:31];
   endfunction

endpackage

`default_nettype wire

/* rtl/dlx_ctrl_pkg.sv */
`default_nettype none

package dlx_ctrl_pkg;

   import dlx_isa_pkg::*;

   // Zero is none so a cleared register decodes as a bubble
   typedef enum logic [3:0] {
      alu_none = 4'h0,
      alu_add  = 4'h1,
      alu_addu = 4'h2,
      alu_sub  = 4'h3,
      alu_subu = 4'h4,
      alu_xor  = 4'h5,
      alu_slt  = 4'h6,
      alu_sge  = 4'h7
   } alu_op_t;

   typedef struct packed {
      logic     reg_wr;
      reg_sel_t reg_dst;
      reg_sel_t rs2_sel;
      logic     ext_op;       // 1 sign extend, 0 zero extend
      logic     alu_src;      // 1 register operand, 0 immediate
      alu_op_t  alu_op;
      logic     mem_wr;
      logic     mem_to_reg;
      logic     branch;
      word_t    new_pc;
      logic     stall;
   } id_ex_ctrl_t;

endpackage

`default_nettype wire

/* rtl/dlx_ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface dlx_ctrl_if
   import dlx_ctrl_pkg::*;
();

   id_ex_ctrl_t ctrl;
   logic        kill_next;         // Load in decode, squash the follower
   logic        should_be_killed;  // Registered copy of kill_next

   modport dec (
      output ctrl,
      output kill_next,
      input  should_be_killed
   );

   modport pipe (
      input  ctrl,
      input  kill_next,
      output should_be_killed
   );

endinterface

`default_nettype wire

/* rtl/dlx_jump_branch.sv */
`timescale 1ns/1ns
`default_nettype none

module dlx_jump_branch
   import dlx_isa_pkg::*;
(
   input  wire instr_t instr,
   input  wire word_t  rs1,
   input  wire word_t  pc_plus_four,
   output word_t       target,
   output logic        take
);

   opcode_t     op;
   logic [15:0] imm16;
   logic [25:0] off26;
   word_t       br_target;
   word_t       j_target;

   assign op    = opcode_of(instr);
   assign imm16 = imm16_of(instr);
   assign off26 = off26_of(instr);

   assign j_target  = pc_plus_four + {{6{off26[25]}}, off26};
   assign br_target = pc_plus_four + {{16{imm16[15]}}, imm16};

   always_comb begin
      target = '0;
      take   = 1'b0;
      case (op)
         op_j, op_jal: begin
            target = j_target;
            take   = 1'b1;
         end
         op_jr, op_jalr: begin
            target = rs1;   // Register indirect
            take   = 1'b1;
         end
         op_beqz: begin
            take   = (rs1 == '0);
            target = take ? br_target : '0;
         end
         op_bnez: begin
            take   = (rs1 != '0);
            target = take ? br_target : '0;
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/dlx_control.sv */
`timescale 1ns/1ns
`default_nettype none

module dlx_control
   import dlx_isa_pkg::*;
   import dlx_ctrl_pkg::*;
(
   input  wire instr_t instr,
   input  wire word_t  rs1,
   input  wire word_t  pc_plus_four,
   dlx_ctrl_if.dec     cif
);

   opcode_t op;
   opcode_t func;
   logic    r_type;
   logic    is_nop;
   logic    is_jump;
   logic    is_branch;
   logic    i_type;
   logic    is_load;
   logic    is_store;
   logic    killed;
   logic    take;
   word_t   target;
   alu_op_t alu_op;

   assign op     = opcode_of(instr);
   assign func   = func_of(instr);
   assign killed = cif.should_be_killed;

   assign r_type    = (op == op_rtype);
   assign is_nop    = r_type && (func == fn_nop);
   assign is_jump   = op inside {op_j, op_jal, op_jr, op_jalr};
   assign is_branch = op inside {op_beqz, op_bnez};
   assign i_type    = !r_type && !is_jump && !is_branch;
   assign is_load   = op inside {op_lb, op_lh, op_lw};
   assign is_store  = op inside {op_sb, op_sh, op_sw};

   dlx_jump_branch u_jump_branch (
      .instr        (instr),
      .rs1          (rs1),
      .pc_plus_four (pc_plus_four),
      .target       (target),
      .take         (take)
   );

   always_comb begin
      alu_op = alu_none;
      if (r_type) begin
         case (func)
            fn_add:  alu_op = alu_add;
            fn_addu: alu_op = alu_addu;
            fn_sub:  alu_op = alu_sub;
            fn_subu: alu_op = alu_subu;
            fn_xor:  alu_op = alu_xor;
            fn_slt:  alu_op = alu_slt;
            default: alu_op = alu_none;   // nop lands here
         endcase
      end else begin
         case (op)
            op_addi, op_lb, op_lh, op_lw, op_sb, op_sh, op_sw: alu_op = alu_add;
            op_addui: alu_op = alu_addu;
            op_subi:  alu_op = alu_sub;
            op_subui: alu_op = alu_subu;
            op_sgei:  alu_op = alu_sge;
            default:  alu_op = alu_none;
         endcase
      end
   end

   always_comb begin
      cif.ctrl.reg_wr     = ((r_type && !is_nop) || (i_type && !is_store)) && !killed;
      cif.ctrl.reg_dst    = r_type ? rd_r_of(instr) : rd_i_of(instr);
      cif.ctrl.rs2_sel    = rd_i_of(instr);
      cif.ctrl.ext_op     = op inside {op_addi, op_subi, op_sgei} || is_load || is_store;
      cif.ctrl.alu_src    = r_type;
      cif.ctrl.alu_op     = alu_op;
      cif.ctrl.mem_wr     = is_store && !killed;
      cif.ctrl.mem_to_reg = is_load && !killed;
      cif.ctrl.branch     = take && !killed;
      cif.ctrl.new_pc     = target;
      cif.ctrl.stall      = is_load && !killed;   // Load-use bubble
   end

   assign cif.kill_next = is_load && !killed;

   // A store never also selects load data for writeback
   always_comb begin
      assert (!(cif.ctrl.mem_wr && cif.ctrl.mem_to_reg))
         else $error("mem_wr and mem_to_reg both high, opcode %h", op);
   end

endmodule

`default_nettype wire

/* rtl/dlx_id_ex_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module dlx_id_ex_reg
   import dlx_ctrl_pkg::*;
(
   input  wire      clk,
   input  wire      rst_n,
   dlx_ctrl_if.pipe cif,
   output id_ex_ctrl_t ex_ctrl
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_ctrl <= '0;   // Bubble after reset
      end else begin
         ex_ctrl <= cif.ctrl;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cif.should_be_killed <= 1'b0;
      end else begin
         cif.should_be_killed <= cif.kill_next;
      end
   end

   // A killed instruction cannot itself start a new kill
   property p_kill_no_chain;
      @(posedge clk) disable iff (!rst_n)
         cif.should_be_killed |=> !cif.should_be_killed;
   endproperty

   a_kill_no_chain: assert property (p_kill_no_chain)
      else $error("should_be_killed high in two consecutive cycles");

endmodule

`default_nettype wire

/* rtl/dlx_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module dlx_decode_stage
   import dlx_isa_pkg::*;
   import dlx_ctrl_pkg::*;
(
   input  wire         clk,
   input  wire         rst_n,
   input  wire instr_t instr,
   input  wire word_t  rs1,
   input  wire word_t  pc_plus_four,
   output logic        reg_wr,
   output reg_sel_t    reg_dst,
   output reg_sel_t    rs2_sel,
   output logic        ext_op,
   output logic        alu_src,
   output alu_op_t     alu_op,
   output logic        mem_wr,
   output logic        mem_to_reg,
   output logic        branch,
   output word_t       new_pc,
   output logic        stall
);

   id_ex_ctrl_t ex_ctrl;

   dlx_ctrl_if u_ctrl_if ();

   dlx_control u_control (
      .instr        (instr),
      .rs1          (rs1),
      .pc_plus_four (pc_plus_four),
      .cif          (u_ctrl_if.dec)
   );

   dlx_id_ex_reg u_id_ex_reg (
      .clk     (clk),
      .rst_n   (rst_n),
      .cif     (u_ctrl_if.pipe),
      .ex_ctrl (ex_ctrl)
   );

   assign reg_wr     = ex_ctrl.reg_wr;
   assign reg_dst    = ex_ctrl.reg_dst;
   assign rs2_sel    = ex_ctrl.rs2_sel;
   assign ext_op     = ex_ctrl.ext_op;
   assign alu_src    = ex_ctrl.alu_src;
   assign alu_op     = ex_ctrl.alu_op;
   assign mem_wr     = ex_ctrl.mem_wr;
   assign mem_to_reg = ex_ctrl.mem_to_reg;
   assign branch     = ex_ctrl.branch;
   assign new_pc     = ex_ctrl.new_pc;
   assign stall      = ex_ctrl.stall;

endmodule

`default_nettype wire

/* sim/tb_dlx_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dlx_decode_stage
   import dlx_isa_pkg::*;
   import dlx_ctrl_pkg::*;
();

   localparam int rec_words   = 14;
   localparam int max_records = 64;
   localparam int max_cycles  = max_records + 8;

   logic     clk;
   logic     rst_n;
   instr_t   instr;
   word_t    rs1;
   word_t    pc_plus_four;
   logic     reg_wr;
   reg_sel_t reg_dst;
   reg_sel_t rs2_sel;
   logic     ext_op;
   logic     alu_src;
   alu_op_t  alu_op;
   logic     mem_wr;
   logic     mem_to_reg;
   logic     branch;
   word_t    new_pc;
   logic     stall;

   logic [31:0] stim [0:rec_words*max_records];   // Word 0 holds the record count
   int          n_tests;
   int          n_failed;

   dlx_decode_stage dlx_decode_stage_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr        (instr),
      .rs1          (rs1),
      .pc_plus_four (pc_plus_four),
      .reg_wr       (reg_wr),
      .reg_dst      (reg_dst),
      .rs2_sel      (rs2_sel),
      .ext_op       (ext_op),
      .alu_src      (alu_src),
      .alu_op       (alu_op),
      .mem_wr       (mem_wr),
      .mem_to_reg   (mem_to_reg),
      .branch       (branch),
      .new_pc       (new_pc),
      .stall        (stall)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // new_pc left at zero, it goes through check_word
   function automatic id_ex_ctrl_t sample_ctrl();
      id_ex_ctrl_t c;
      c            = '0;
      c.reg_wr     = reg_wr;
      c.reg_dst    = reg_dst;
      c.rs2_sel    = rs2_sel;
      c.ext_op     = ext_op;
      c.alu_src    = alu_src;
      c.alu_op     = alu_op;
      c.mem_wr     = mem_wr;
      c.mem_to_reg = mem_to_reg;
      c.branch     = branch;
      c.stall      = stall;
      return c;
   endfunction

   function automatic id_ex_ctrl_t expected_ctrl(int base);
      id_ex_ctrl_t c;
      c            = '0;
      c.reg_wr     = stim[base+3][0];
      c.reg_dst    = stim[base+4][4:0];
      c.rs2_sel    = stim[base+5][4:0];
      c.ext_op     = stim[base+6][0];
      c.alu_src    = stim[base+7][0];
      c.alu_op     = alu_op_t'(stim[base+8][3:0]);
      c.mem_wr     = stim[base+9][0];
      c.mem_to_reg = stim[base+10][0];
      c.branch     = stim[base+11][0];
      c.stall      = stim[base+12][0];
      return c;
   endfunction

   task automatic check_ctrl(string name, id_ex_ctrl_t exp, id_ex_ctrl_t act);
      n_tests++;
      if (act !== exp) begin
         n_failed++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end else begin
         $display("PASSED %s", name);
      end
   endtask

   task automatic check_word(string name, word_t exp, word_t act);
      n_tests++;
      if (act !== exp) begin
         n_failed++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end else begin
         $display("PASSED %s", name);
      end
   endtask

   initial begin
      int n_rec;
      int base;
      int cycles;
      int k;
      instr        = 32'h0000_0015;   // nop
      rs1          = '0;
      pc_plus_four = '0;
      rst_n        = 1'b0;
      n_tests      = 0;
      n_failed     = 0;
      $readmemh("sim/decode_stimulus.txt", stim);
      n_rec = int'(stim[0]);

      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);   // No capture yet
      check_ctrl("reset ctrl", '0, sample_ctrl());
      check_word("reset new_pc", '0, new_pc);

      if (n_rec < 1 || n_rec > max_records) begin
         $display("Stimulus file holds %0d records, outside 1 to %0d", n_rec, max_records);
         n_failed++;
         n_rec = 0;
      end

      // One record per cycle, checked one cycle after it was driven
      k      = 0;
      cycles = 0;
      while (k <= n_rec && cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
         if (k < n_rec) begin
            base = 1 + k * rec_words;
            instr        <= stim[base];
            rs1          <= stim[base+1];
            pc_plus_four <= stim[base+2];
         end else begin
            instr <= 32'h0000_0015;
         end
         @(negedge clk);
         if (k > 0) begin
            base = 1 + (k - 1) * rec_words;
            check_ctrl($sformatf("record %0d ctrl", k - 1), expected_ctrl(base), sample_ctrl());
            check_word($sformatf("record %0d new_pc", k - 1), stim[base+13], new_pc);
         end
         k++;
      end
      if (k <= n_rec) begin
         $display("Timeout: stimulus loop stopped after %0d cycles", cycles);
         n_failed++;
      end

      $display("Checks run %0d, failed %0d", n_tests, n_failed);
      if (n_failed == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
rtl/dlx_isa_pkg.sv
rtl/dlx_ctrl_pkg.sv
rtl/dlx_ctrl_if.sv
rtl/dlx_jump_branch.sv
rtl/dlx_control.sv
rtl/dlx_id_ex_reg.sv
rtl/dlx_decode_stage.sv
sim/tb_dlx_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb_dlx_decode_stage -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
   echo "No result line found in sim.log"
   exit 1
fi

/* sim/decode_stimulus.txt */
// First word is the record count. Then per line: instr rs1 pc_plus_four, expected reg_wr
// reg_dst rs2_sel ext_op alu_src alu_op mem_wr mem_to_reg branch stall new_pc
0000001E
00221820 00000005 00000100 1 03 02 0 1 1 0 0 0 0 00000000
00A62022 00000005 00000100 1 04 06 0 1 3 0 0 0 0 00000000
01093826 00000005 00000100 1 07 09 0 1 5 0 0 0 0 00000000
016C502A 00000005 00000100 1 0A 0C 0 1 6 0 0 0 0 00000000
00430821 00000005 00000100 1 01 03 0 1 2 0 0 0 0 00000000
00641023 00000005 00000100 1 02 04 0 1 4 0 0 0 0 00000000
00000015 00000005 00000100 0 00 00 0 1 0 0 0 0 0 00000000
20250010 00000005 00000100 1 05 05 1 0 1 0 0 0 0 00000000
2446FFFF 00000005 00000100 1 06 06 0 0 2 0 0 0 0 00000000
28670004 00000005 00000100 1 07 07 1 0 3 0 0 0 0 00000000
2C280001 00000005 00000100 1 08 08 0 0 4 0 0 0 0 00000000
74490003 00000005 00000100 1 09 09 1 0 7 0 0 0 0 00000000
AC240008 00000005 00000100 0 04 04 1 0 1 1 0 0 0 00000000
A4450002 00000005 00000100 0 05 05 1 0 1 1 0 0 0 00000000
A0660001 00000005 00000100 0 06 06 1 0 1 1 0 0 0 00000000
8C2A0004 00000005 00000100 1 0A 0A 1 0 1 0 1 0 1 00000000
00221820 00000005 00000100 0 03 02 0 1 1 0 0 0 0 00000000
00A62022 00000005 00000100 1 04 06 0 1 3 0 0 0 0 00000000
844B0006 00000005 00000100 1 0B 0B 1 0 1 0 1 0 1 00000000
AC240008 00000005 00000100 0 04 04 1 0 1 0 0 0 0 00000000
806C0000 00000005 00000100 1 0C 0C 1 0 1 0 1 0 1 00000000
10200010 00000000 00000200 0 00 00 0 0 0 0 0 0 0 00000210
10200010 00000000 00000200 0 00 00 0 0 0 0 0 1 0 00000210
10200010 00000005 00000200 0 00 00 0 0 0 0 0 0 0 00000000
1420FFF0 00000007 00000300 0 00 00 0 0 0 0 0 1 0 000002F0
1420FFF0 00000000 00000300 0 00 00 0 0 0 0 0 0 0 00000000
08000100 00000005 00001000 0 00 00 0 0 0 0 0 1 0 00001100
0FFFFFF0 00000005 00001000 0 1F 1F 0 0 0 0 0 1 0 00000FF0
48800000 00002468 00001000 0 00 00 0 0 0 0 0 1 0 00002468
4CA00000 0000ABC0 00001000 0 00 00 0 0 0 0 0 1 0 0000ABC0
